//--- src/ooo_config.svh
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// data path width
`define OOO_XLEN 32

// register counts, architectural and physical
`define OOO_NUM_AREGS 32
`define OOO_NUM_PREGS 48

// window sizes
`define OOO_ROB_DEPTH 16
`define OOO_IQ_DEPTH 8

`endif

//--- src/isa_pkg.sv
`include "ooo_config.svh"

package isa_pkg;

  // operation encoding at dispatch
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_LI   = 3'd5,
    OP_HALT = 3'd6
  } opcode_e;

  // architectural register index
  typedef logic [$clog2(`OOO_NUM_AREGS)-1:0] areg_t;

  typedef logic [`OOO_XLEN-1:0] word_t;

endpackage

//--- src/uarch_pkg.sv
`include "ooo_config.svh"

package uarch_pkg;

  // physical register tag
  typedef logic [$clog2(`OOO_NUM_PREGS)-1:0] preg_t;

  typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_idx_t;

  // tag 0 holds register zero for good
  localparam preg_t PREG_ZERO = '0;

  // operation after renaming
  typedef struct packed {
    isa_pkg::opcode_e op;
    isa_pkg::areg_t   dest_areg;
    preg_t            dest_preg;
    preg_t            old_preg;
    preg_t            src1_preg;
    preg_t            src2_preg;
    logic             src1_ready;
    logic             src2_ready;
    isa_pkg::word_t   imm;
    rob_idx_t         rob_idx;
  } renamed_op_t;

endpackage

//--- src/cdb_if.sv
`timescale 1ns/1ps

interface cdb_if;
  import isa_pkg::*;
  import uarch_pkg::*;

  // one broadcast per cycle, never stalled
  logic     valid;
  preg_t    tag;
  rob_idx_t rob_idx;
  word_t    value;

  modport producer (output valid, output tag, output rob_idx, output value);

  modport consumer (input valid, input tag, input rob_idx, input value);

endinterface

//--- src/rename_unit.sv
`timescale 1ns/1ps
`include "ooo_config.svh"

module rename_unit (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   dispatch_valid,
  input  isa_pkg::opcode_e       dispatch_op,
  input  isa_pkg::areg_t         dispatch_dest,
  input  isa_pkg::areg_t         dispatch_src1,
  input  isa_pkg::areg_t         dispatch_src2,
  input  isa_pkg::word_t         dispatch_imm,
  input  logic                   iq_full,
  input  logic                   rob_full,
  input  uarch_pkg::rob_idx_t    rob_tail,
  input  logic                   free_valid,
  input  uarch_pkg::preg_t       free_preg,
  cdb_if.consumer                cdb,
  output logic                   dispatch_ready,
  output logic                   alloc,
  output uarch_pkg::renamed_op_t renamed
);
  import isa_pkg::*;
  import uarch_pkg::*;

  localparam int FL_DEPTH = `OOO_NUM_PREGS - `OOO_NUM_AREGS;
  localparam int FL_PTR_W = $clog2(FL_DEPTH);

  preg_t                     map_table [`OOO_NUM_AREGS];
  preg_t                     free_list [FL_DEPTH];
  logic [FL_PTR_W-1:0]       fl_head;
  logic [FL_PTR_W-1:0]       fl_tail;
  logic [FL_PTR_W:0]         fl_count;
  logic [`OOO_NUM_PREGS-1:0] busy;
  logic                      halt_seen;
  logic                      is_halt;
  logic                      uses_srcs;
  logic                      needs_tag;
  logic                      take_tag;
  preg_t                     src1_tag;
  preg_t                     src2_tag;

  assign is_halt   = (dispatch_op == OP_HALT);
  // li and halt read no registers
  assign uses_srcs = !is_halt && (dispatch_op != OP_LI);
  assign needs_tag = !is_halt && (dispatch_dest != '0);

  // halt never enters the issue queue
  assign dispatch_ready = !halt_seen && !rob_full && (is_halt || !iq_full) &&
                          (!needs_tag || fl_count != '0);
  assign alloc    = dispatch_valid && dispatch_ready;
  assign take_tag = alloc && needs_tag;

  assign src1_tag = uses_srcs ? map_table[dispatch_src1] : PREG_ZERO;
  assign src2_tag = uses_srcs ? map_table[dispatch_src2] : PREG_ZERO;

  always_comb begin
    renamed.op         = dispatch_op;
    renamed.dest_areg  = dispatch_dest;
    renamed.dest_preg  = needs_tag ? free_list[fl_head] : PREG_ZERO;
    renamed.old_preg   = map_table[dispatch_dest];
    renamed.src1_preg  = src1_tag;
    renamed.src2_preg  = src2_tag;
    // not busy, or the value is on the bus this cycle
    renamed.src1_ready = !busy[src1_tag] || (cdb.valid && cdb.tag == src1_tag);
    renamed.src2_ready = !busy[src2_tag] || (cdb.valid && cdb.tag == src2_tag);
    renamed.imm        = dispatch_imm;
    renamed.rob_idx    = rob_tail;
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      // identity map, upper tags start free
      for (int i = 0; i < `OOO_NUM_AREGS; i++) begin
        map_table[i] <= preg_t'(i);
      end
      for (int i = 0; i < FL_DEPTH; i++) begin
        free_list[i] <= preg_t'(`OOO_NUM_AREGS + i);
      end
      fl_head   <= '0;
      fl_tail   <= '0;
      fl_count  <= (FL_PTR_W+1)'(FL_DEPTH);
      busy      <= '0;
      halt_seen <= 1'b0;
    end else begin
      if (take_tag) begin
        map_table[dispatch_dest] <= free_list[fl_head];
        fl_head                  <= fl_head + 1'b1;
      end
      // retired old tag goes back on the list
      if (free_valid) begin
        free_list[fl_tail] <= free_preg;
        fl_tail            <= fl_tail + 1'b1;
      end
      if (take_tag && !free_valid) begin
        fl_count <= fl_count - 1'b1;
      end else if (free_valid && !take_tag) begin
        fl_count <= fl_count + 1'b1;
      end
      if (cdb.valid) begin
        busy[cdb.tag] <= 1'b0;
      end
      if (take_tag) begin
        busy[free_list[fl_head]] <= 1'b1;
      end
      if (alloc && is_halt) begin
        halt_seen <= 1'b1;
      end
    end
  end

endmodule

//--- src/issue_queue.sv
`timescale 1ns/1ps
`include "ooo_config.svh"

module issue_queue (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   alloc,
  input  uarch_pkg::renamed_op_t renamed,
  cdb_if.consumer                cdb,
  output logic                   iq_full,
  output logic                   issue_valid,
  output uarch_pkg::renamed_op_t issue_op
);
  import isa_pkg::*;
  import uarch_pkg::*;

  localparam int IQ_PTR_W = $clog2(`OOO_IQ_DEPTH);

  renamed_op_t               entry [`OOO_IQ_DEPTH];
  logic [`OOO_IQ_DEPTH-1:0]  valid;
  logic [`OOO_IQ_DEPTH-1:0]  ready;
  logic [IQ_PTR_W-1:0]       free_idx;
  logic [IQ_PTR_W-1:0]       sel_idx;
  logic                      sel_found;
  logic                      write_en;

  assign iq_full  = &valid;
  // halt only takes a ROB slot
  assign write_en = alloc && (renamed.op != OP_HALT);

  // entries with both operands available
  always_comb begin
    for (int i = 0; i < `OOO_IQ_DEPTH; i++) begin
      ready[i] = valid[i] && entry[i].src1_ready && entry[i].src2_ready;
    end
  end

  // scan downward so the lowest index wins
  always_comb begin
    free_idx  = '0;
    sel_idx   = '0;
    sel_found = 1'b0;
    for (int i = `OOO_IQ_DEPTH - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        free_idx = IQ_PTR_W'(i);
      end
      if (ready[i]) begin
        sel_idx   = IQ_PTR_W'(i);
        sel_found = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      valid       <= '0;
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= sel_found;
      // selected and free slots never coincide
      if (sel_found) begin
        valid[sel_idx] <= 1'b0;
      end
      if (write_en) begin
        valid[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    // wakeup from the result bus
    for (int i = 0; i < `OOO_IQ_DEPTH; i++) begin
      if (cdb.valid && entry[i].src1_preg == cdb.tag) begin
        entry[i].src1_ready <= 1'b1;
      end
      if (cdb.valid && entry[i].src2_preg == cdb.tag) begin
        entry[i].src2_ready <= 1'b1;
      end
    end
    if (write_en) begin
      entry[free_idx] <= renamed;
    end
    if (sel_found) begin
      issue_op <= entry[sel_idx];
    end
  end

endmodule

//--- src/exec_unit.sv
`timescale 1ns/1ps
`include "ooo_config.svh"

module exec_unit (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   issue_valid,
  input  uarch_pkg::renamed_op_t issue_op,
  cdb_if.producer                cdb
);
  import isa_pkg::*;
  import uarch_pkg::*;

  word_t    prf [`OOO_NUM_PREGS];
  logic     s1_valid;
  opcode_e  s1_op;
  preg_t    s1_tag;
  rob_idx_t s1_rob;
  word_t    s1_a;
  word_t    s1_b;
  word_t    result;

  always_ff @(posedge clock) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      cdb.valid <= 1'b0;
    end else begin
      s1_valid  <= issue_valid;
      cdb.valid <= s1_valid;
    end
  end

  // stage one, operand read; li carries its immediate as b
  always_ff @(posedge clock) begin
    s1_op  <= issue_op.op;
    s1_tag <= issue_op.dest_preg;
    s1_rob <= issue_op.rob_idx;
    s1_a   <= prf[issue_op.src1_preg];
    s1_b   <= (issue_op.op == OP_LI) ? issue_op.imm : prf[issue_op.src2_preg];
  end

  always_comb begin
    case (s1_op)
      OP_ADD:  result = s1_a + s1_b;
      OP_SUB:  result = s1_a - s1_b;
      OP_AND:  result = s1_a & s1_b;
      OP_OR:   result = s1_a | s1_b;
      OP_XOR:  result = s1_a ^ s1_b;
      OP_LI:   result = s1_b;
      default: result = '0;
    endcase
  end

  // stage two, broadcast
  always_ff @(posedge clock) begin
    cdb.tag     <= s1_tag;
    cdb.rob_idx <= s1_rob;
    cdb.value   <= result;
  end

  // architectural state starts at zero, tag 0 is never written
  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < `OOO_NUM_PREGS; i++) begin
        prf[i] <= '0;
      end
    end else if (cdb.valid && cdb.tag != PREG_ZERO) begin
      prf[cdb.tag] <= cdb.value;
    end
  end

endmodule

//--- src/reorder_buffer.sv
`timescale 1ns/1ps
`include "ooo_config.svh"

module reorder_buffer (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   alloc,
  input  uarch_pkg::renamed_op_t renamed,
  cdb_if.consumer                cdb,
  output logic                   rob_full,
  output uarch_pkg::rob_idx_t    rob_tail,
  output logic                   free_valid,
  output uarch_pkg::preg_t       free_preg,
  output logic                   commit_valid,
  output logic                   commit_wr_en,
  output isa_pkg::areg_t         commit_reg,
  output isa_pkg::word_t         commit_data,
  output logic                   halted
);
  import isa_pkg::*;
  import uarch_pkg::*;

  localparam int ROB_PTR_W = $clog2(`OOO_ROB_DEPTH);
  localparam logic [ROB_PTR_W:0] FULL_COUNT = `OOO_ROB_DEPTH;

  logic [`OOO_ROB_DEPTH-1:0] done;
  logic [`OOO_ROB_DEPTH-1:0] halt_mark;
  areg_t                     dest_areg [`OOO_ROB_DEPTH];
  preg_t                     old_preg [`OOO_ROB_DEPTH];
  word_t                     value [`OOO_ROB_DEPTH];
  rob_idx_t                  head;
  rob_idx_t                  tail;
  logic [ROB_PTR_W:0]        count;
  logic                      retire;

  assign rob_full = (count == FULL_COUNT);
  assign rob_tail = tail;
  // nothing retires after halt
  assign retire   = !halted && (count != '0) && done[head];

  always_ff @(posedge clock) begin
    if (rst) begin
      head         <= '0;
      tail         <= '0;
      count        <= '0;
      done         <= '0;
      halted       <= 1'b0;
      commit_valid <= 1'b0;
      commit_wr_en <= 1'b0;
      free_valid   <= 1'b0;
    end else begin
      commit_valid <= 1'b0;
      commit_wr_en <= 1'b0;
      free_valid   <= 1'b0;
      if (cdb.valid) begin
        done[cdb.rob_idx] <= 1'b1;
      end
      // halt needs no result
      if (alloc) begin
        done[tail] <= (renamed.op == OP_HALT);
        tail       <= tail + 1'b1;
      end
      if (retire) begin
        head <= head + 1'b1;
        if (halt_mark[head]) begin
          halted <= 1'b1;
        end else begin
          commit_valid <= 1'b1;
          commit_wr_en <= (dest_areg[head] != '0);
          free_valid   <= (dest_areg[head] != '0);
        end
      end
      if (alloc && !retire) begin
        count <= count + 1'b1;
      end else if (retire && !alloc) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      halt_mark[tail] <= (renamed.op == OP_HALT);
      dest_areg[tail] <= renamed.dest_areg;
      old_preg[tail]  <= renamed.old_preg;
    end
    if (cdb.valid) begin
      value[cdb.rob_idx] <= cdb.value;
    end
    if (retire) begin
      commit_reg  <= dest_areg[head];
      commit_data <= value[head];
      free_preg   <= old_preg[head];
    end
  end

endmodule

//--- src/ooo_core.sv
`timescale 1ns/1ps

module ooo_core (
  input  logic             clock,
  input  logic             rst,
  input  logic             dispatch_valid,
  input  isa_pkg::opcode_e dispatch_op,
  input  isa_pkg::areg_t   dispatch_dest,
  input  isa_pkg::areg_t   dispatch_src1,
  input  isa_pkg::areg_t   dispatch_src2,
  input  isa_pkg::word_t   dispatch_imm,
  output logic             dispatch_ready,
  output logic             commit_valid,
  output logic             commit_wr_en,
  output isa_pkg::areg_t   commit_reg,
  output isa_pkg::word_t   commit_data,
  output logic             halted
);

  logic                   alloc;
  logic                   iq_full;
  logic                   rob_full;
  logic                   free_valid;
  logic                   issue_valid;
  uarch_pkg::rob_idx_t    rob_tail;
  uarch_pkg::preg_t       free_preg;
  uarch_pkg::renamed_op_t renamed;
  uarch_pkg::renamed_op_t issue_op;

  // result bus shared by all stages
  cdb_if cdb_0 ();

  rename_unit rename_0 (
    .clock          (clock),
    .rst            (rst),
    .dispatch_valid (dispatch_valid),
    .dispatch_op    (dispatch_op),
    .dispatch_dest  (dispatch_dest),
    .dispatch_src1  (dispatch_src1),
    .dispatch_src2  (dispatch_src2),
    .dispatch_imm   (dispatch_imm),
    .iq_full        (iq_full),
    .rob_full       (rob_full),
    .rob_tail       (rob_tail),
    .free_valid     (free_valid),
    .free_preg      (free_preg),
    .cdb            (cdb_0.consumer),
    .dispatch_ready (dispatch_ready),
    .alloc          (alloc),
    .renamed        (renamed)
  );

  issue_queue iq_0 (
    .clock       (clock),
    .rst         (rst),
    .alloc       (alloc),
    .renamed     (renamed),
    .cdb         (cdb_0.consumer),
    .iq_full     (iq_full),
    .issue_valid (issue_valid),
    .issue_op    (issue_op)
  );

  exec_unit exec_0 (
    .clock       (clock),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .cdb         (cdb_0.producer)
  );

  reorder_buffer rob_0 (
    .clock        (clock),
    .rst          (rst),
    .alloc        (alloc),
    .renamed      (renamed),
    .cdb          (cdb_0.consumer),
    .rob_full     (rob_full),
    .rob_tail     (rob_tail),
    .free_valid   (free_valid),
    .free_preg    (free_preg),
    .commit_valid (commit_valid),
    .commit_wr_en (commit_wr_en),
    .commit_reg   (commit_reg),
    .commit_data  (commit_data),
    .halted       (halted)
  );

endmodule

//--- sim/ooo_core_checker.sv
`timescale 1ns/1ps

module ooo_core_checker (
  input logic clock,
  input logic rst,
  input logic dispatch_ready,
  input logic commit_valid,
  input logic commit_wr_en,
  input logic halted
);

  int assert_failures = 0;

  // a register write only comes with a commit
  a_wr_needs_valid: assert property (
    @(posedge clock) disable iff (rst) commit_wr_en |-> commit_valid
  ) else begin
    assert_failures++;
    $error("commit_wr_en high without commit_valid");
  end

  // core takes nothing once halted
  a_no_dispatch_halted: assert property (
    @(posedge clock) disable iff (rst) halted |-> !dispatch_ready
  ) else begin
    assert_failures++;
    $error("dispatch_ready high while halted");
  end

  a_no_commit_halted: assert property (
    @(posedge clock) disable iff (rst) halted |-> !commit_valid
  ) else begin
    assert_failures++;
    $error("commit_valid high while halted");
  end

  a_reset_clears_commit: assert property (
    @(posedge clock) rst |=> !commit_valid
  ) else begin
    assert_failures++;
    $error("commit_valid high in the cycle after reset");
  end

endmodule

bind ooo_core ooo_core_checker i_checker (
  .clock          (clock),
  .rst            (rst),
  .dispatch_ready (dispatch_ready),
  .commit_valid   (commit_valid),
  .commit_wr_en   (commit_wr_en),
  .halted         (halted)
);

//--- sim/ooo_core_tb.sv
`timescale 1ns/1ps
`include "ooo_config.svh"

module ooo_core_tb;
  import isa_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 4;
  localparam int SAMPLE_SKEW  = 1;
  localparam int SEED         = 32812;
  localparam int RANDOM_OPS   = 300;
  localparam int CHAIN_LEN    = 40;
  localparam int HOLD_CYCLES  = 10;
  // all tests together stay under 400 instructions
  localparam int TIMEOUT_CYCLES = 400 * 20;

  logic    clock;
  logic    rst;
  logic    dispatch_valid;
  opcode_e dispatch_op;
  areg_t   dispatch_dest;
  areg_t   dispatch_src1;
  areg_t   dispatch_src2;
  word_t   dispatch_imm;
  logic    dispatch_ready;
  logic    commit_valid;
  logic    commit_wr_en;
  areg_t   commit_reg;
  word_t   commit_data;
  logic    halted;

  // architectural model, expected commits in program order
  word_t arch_rf [`OOO_NUM_AREGS];
  areg_t exp_reg [$];
  logic  exp_wr [$];
  word_t exp_data [$];

  string current_test;
  int    test_errors  = 0;
  int    total_errors = 0;
  int    checks       = 0;
  int    tests_run    = 0;
  int    tests_failed = 0;
  int    accepted_ops = 0;
  int    commit_count = 0;
  int    stall_cycles = 0;
  int    cycle_count  = 0;

  ooo_core i_dut (
    .clock          (clock),
    .rst            (rst),
    .dispatch_valid (dispatch_valid),
    .dispatch_op    (dispatch_op),
    .dispatch_dest  (dispatch_dest),
    .dispatch_src1  (dispatch_src1),
    .dispatch_src2  (dispatch_src2),
    .dispatch_imm   (dispatch_imm),
    .dispatch_ready (dispatch_ready),
    .commit_valid   (commit_valid),
    .commit_wr_en   (commit_wr_en),
    .commit_reg     (commit_reg),
    .commit_data    (commit_data),
    .halted         (halted)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  task automatic note_error(input string msg);
    $display("%s", msg);
    test_errors++;
    total_errors++;
  endtask

  task automatic check_areg(input string what, input areg_t exp_val, input areg_t act_val);
    checks++;
    if (act_val !== exp_val) begin
      note_error($sformatf("Error: %s %s expected %0d actual %0d",
                           current_test, what, exp_val, act_val));
    end
  endtask

  task automatic check_word(input string what, input word_t exp_val, input word_t act_val);
    checks++;
    if (act_val !== exp_val) begin
      note_error($sformatf("Error: %s %s expected 0x%08h actual 0x%08h",
                           current_test, what, exp_val, act_val));
    end
  endtask

  task automatic check_flag(input string what, input logic exp_val, input logic act_val);
    checks++;
    if (act_val !== exp_val) begin
      note_error($sformatf("Error: %s %s expected %b actual %b",
                           current_test, what, exp_val, act_val));
    end
  endtask

  function automatic word_t model_result(opcode_e op, word_t a, word_t b, word_t imm);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_LI:   return imm;
      default: return '0;
    endcase
  endfunction

  // runs one accepted op on the model, halt leaves no commit
  task automatic model_accept(opcode_e op, areg_t dest, areg_t src1, areg_t src2, word_t imm);
    word_t result;
    if (op != OP_HALT) begin
      result = model_result(op, arch_rf[src1], arch_rf[src2], imm);
      if (dest != '0) begin
        arch_rf[dest] = result;
      end
      exp_reg.push_back(dest);
      exp_wr.push_back(dest != '0);
      exp_data.push_back(result);
      accepted_ops++;
    end
  endtask

  task automatic check_commit();
    areg_t reg_e;
    logic  wr_e;
    word_t data_e;
    commit_count++;
    if (exp_reg.size() == 0) begin
      note_error($sformatf("%s: a commit appeared with no operation outstanding",
                           current_test));
    end else begin
      reg_e  = exp_reg.pop_front();
      wr_e   = exp_wr.pop_front();
      data_e = exp_data.pop_front();
      check_areg("commit_reg", reg_e, commit_reg);
      check_flag("commit_wr_en", wr_e, commit_wr_en);
      // data only matters when a register is written
      if (wr_e) begin
        check_word("commit_data", data_e, commit_data);
      end
    end
  endtask

  // commit ports are registered and settled at the falling edge
  always @(negedge clock) begin
    if (commit_valid === 1'b1) begin
      check_commit();
    end
  end

  // called at a falling edge, returns at the falling edge after acceptance
  task automatic send_op(opcode_e op, areg_t dest, areg_t src1, areg_t src2, word_t imm);
    logic taken;
    dispatch_valid = 1'b1;
    dispatch_op    = op;
    dispatch_dest  = dest;
    dispatch_src1  = src1;
    dispatch_src2  = src2;
    dispatch_imm   = imm;
    taken = 1'b0;
    while (!taken) begin
      // just before the rising edge that decides acceptance
      #(CLK_PERIOD / 2 - SAMPLE_SKEW);
      taken = dispatch_ready;
      if (taken) begin
        model_accept(op, dest, src1, src2, imm);
      end else begin
        stall_cycles++;
      end
      @(negedge clock);
    end
    dispatch_valid = 1'b0;
  endtask

  task automatic idle_cycle();
    dispatch_valid = 1'b0;
    @(negedge clock);
  endtask

  // returns at a falling edge so the next test can drive right away
  task automatic wait_drain();
    while (exp_reg.size() != 0) begin
      @(negedge clock);
    end
    if (commit_count != accepted_ops) begin
      note_error($sformatf("Error: %s commit count expected %0d actual %0d",
                           current_test, accepted_ops, commit_count));
    end
  endtask

  task automatic test_begin(input string name);
    current_test = name;
    test_errors  = 0;
    tests_run++;
  endtask

  task automatic test_end();
    if (test_errors == 0) begin
      $display("[ok]   %s", current_test);
    end else begin
      tests_failed++;
      $display("[FAIL] %s with %0d errors", current_test, test_errors);
    end
  endtask

  task automatic run_reset_test();
    test_begin("reset_state");
    check_flag("dispatch_ready", 1'b1, dispatch_ready);
    check_flag("commit_valid", 1'b0, commit_valid);
    check_flag("halted", 1'b0, halted);
    test_end();
  endtask

  // small register window keeps dependencies dense
  task automatic run_random_test();
    opcode_e op;
    areg_t   dest;
    areg_t   src1;
    areg_t   src2;
    word_t   imm;
    test_begin("random_program");
    for (int i = 0; i < RANDOM_OPS; i++) begin
      if ($urandom_range(3) == 0) begin
        idle_cycle();
      end
      op   = opcode_e'($urandom_range(5));
      dest = areg_t'($urandom_range(7));
      src1 = areg_t'($urandom_range(7));
      src2 = areg_t'($urandom_range(7));
      imm  = $urandom();
      send_op(op, dest, src1, src2, imm);
    end
    wait_drain();
    test_end();
  endtask

  task automatic run_zero_reg_test();
    test_begin("zero_register");
    send_op(OP_LI, 5'd0, 5'd0, 5'd0, 32'hdead_beef);
    send_op(OP_ADD, 5'd3, 5'd0, 5'd0, '0);
    send_op(OP_LI, 5'd4, 5'd0, 5'd0, 32'h0000_1234);
    send_op(OP_OR, 5'd5, 5'd4, 5'd0, '0);
    send_op(OP_XOR, 5'd0, 5'd4, 5'd5, '0);
    send_op(OP_SUB, 5'd6, 5'd0, 5'd4, '0);
    send_op(OP_AND, 5'd7, 5'd0, 5'd5, '0);
    wait_drain();
    test_end();
  endtask

  // serial add chain on x1 with independent li work behind it
  task automatic run_backpressure_test();
    int stalls_before;
    test_begin("backpressure_chain");
    stalls_before = stall_cycles;
    send_op(OP_LI, 5'd1, 5'd0, 5'd0, 32'd1);
    send_op(OP_LI, 5'd2, 5'd0, 5'd0, 32'd3);
    for (int i = 0; i < CHAIN_LEN; i++) begin
      send_op(OP_ADD, 5'd1, 5'd1, 5'd2, '0);
      send_op(OP_LI, areg_t'(8 + i % 4), 5'd0, 5'd0, word_t'(i));
    end
    wait_drain();
    if (stall_cycles == stalls_before) begin
      note_error($sformatf("%s: dispatch_ready never dropped under the dependency chain",
                           current_test));
    end
    test_end();
  endtask

  task automatic run_halt_test();
    int commits_at_halt;
    test_begin("halt_stop");
    send_op(OP_LI, 5'd1, 5'd0, 5'd0, 32'h0000_0055);
    send_op(OP_ADD, 5'd2, 5'd1, 5'd1, '0);
    send_op(OP_XOR, 5'd3, 5'd2, 5'd1, '0);
    send_op(OP_HALT, 5'd0, 5'd0, 5'd0, '0);
    // keep offering work, none of it may be taken
    dispatch_valid = 1'b1;
    dispatch_op    = OP_ADD;
    dispatch_dest  = 5'd1;
    dispatch_src1  = 5'd1;
    dispatch_src2  = 5'd1;
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      #(CLK_PERIOD / 2 - SAMPLE_SKEW);
      check_flag("dispatch_ready", 1'b0, dispatch_ready);
      if (dispatch_ready) begin
        model_accept(OP_ADD, 5'd1, 5'd1, 5'd1, '0);
      end
      @(negedge clock);
    end
    dispatch_valid = 1'b0;
    while (halted !== 1'b1) begin
      @(negedge clock);
    end
    @(posedge clock);
    if (exp_reg.size() != 0) begin
      note_error($sformatf("%s: halted rose with %0d older operations not committed",
                           current_test, exp_reg.size()));
    end
    commits_at_halt = commit_count;
    repeat (HOLD_CYCLES) @(posedge clock);
    if (commit_count != commits_at_halt) begin
      note_error($sformatf("%s: a commit appeared after halted rose", current_test));
    end
    check_flag("halted", 1'b1, halted);
    wait_drain();
    test_end();
  endtask

  initial begin
    int assertion_failures;
    void'($urandom(SEED));
    rst            = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_op    = OP_ADD;
    dispatch_dest  = '0;
    dispatch_src1  = '0;
    dispatch_src2  = '0;
    dispatch_imm   = '0;
    for (int i = 0; i < `OOO_NUM_AREGS; i++) begin
      arch_rf[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;
    run_reset_test();
    run_random_test();
    run_zero_reg_test();
    run_backpressure_test();
    run_halt_test();
    assertion_failures = i_dut.i_checker.assert_failures;
    $display("%0d tests, %0d failing, %0d checks, %0d errors, %0d assertion failures",
             tests_run, tests_failed, checks, total_errors, assertion_failures);
    if (total_errors == 0 && tests_failed == 0 && assertion_failures == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

//--- ooo_core.f
+incdir+src
src/isa_pkg.sv
src/uarch_pkg.sv
src/cdb_if.sv
src/rename_unit.sv
src/issue_queue.sv
src/exec_unit.sv
src/reorder_buffer.sv
src/ooo_core.sv
sim/ooo_core_checker.sv
sim/ooo_core_tb.sv

//--- Bender.yml
package:
  name: ooo_core

sources:
  - include_dirs:
      - src
    files:
      - src/isa_pkg.sv
      - src/uarch_pkg.sv
      - src/cdb_if.sv
      - src/rename_unit.sv
      - src/issue_queue.sv
      - src/exec_unit.sv
      - src/reorder_buffer.sv
      - src/ooo_core.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/ooo_core_checker.sv
      - sim/ooo_core_tb.sv
